/* dv/sort_array_tb.sv */
module sort_array_tb;

    localparam int N            = 4;
    localparam int SORT_CYCLES  = 3 * N;
    localparam int DONE_TIMEOUT = 4 * SORT_CYCLES + 20;
    localparam logic [31:0] SEED = 32'h6cbb639d;

    logic            clk;
    logic            rst;
    logic            load;
    logic            start;
    logic            busy;
    logic            done;
    sort_pkg::pair_t load_pair;
    sort_pkg::pair_t sorted [N];

    // reference model of the element storage
    sort_pkg::pair_t model [N];
    sort_pkg::pair_t expect_pairs [N];
    sort_pkg::data_t vals [2*N];
    int              model_slot;
    logic [31:0]     rng;

    tb_clk_gen #(
        .PERIOD (4)
    ) u_clk_gen (
        .clk (clk)
    );

    sort_array_top #(
        .NUM_PE (N)
    ) u_dut (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .load_pair (load_pair),
        .start     (start),
        .busy      (busy),
        .done      (done),
        .sorted    (sorted)
    );

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic mismatch(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        stop_run($sformatf("Error at time %0t: %s expected %h, actual %h",
                           $time, name, expected, actual));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // done is a single pulse right after the busy window
    a_done_one_cycle: assert property (@(posedge clk) disable iff (rst)
        done |-> !$past(done))
        else mismatch("done", 32'd0, 32'd1);

    a_done_not_busy: assert property (@(posedge clk) disable iff (rst)
        done |-> !busy)
        else mismatch("busy", 32'd0, 32'd1);

    a_busy_before_done: assert property (@(posedge clk) disable iff (rst)
        done |-> $past(busy))
        else stop_run("busy was low in the cycle before done");

    // busy only rises after a start
    a_busy_needs_start: assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> $past(start))
        else stop_run("busy rose without a start in the cycle before");

    // ascending order of all stored values, element 0 lo first
    task automatic build_expected();
        sort_pkg::data_t key;
        int              j;
        for (int i = 0; i < N; i++) begin
            vals[2*i]   = model[i].lo;
            vals[2*i+1] = model[i].hi;
        end
        for (int i = 1; i < 2 * N; i++) begin
            key = vals[i];
            j = i - 1;
            while (j >= 0) begin
                if (vals[j] <= key) begin
                    break;
                end
                vals[j+1] = vals[j];
                j--;
            end
            vals[j+1] = key;
        end
        for (int i = 0; i < N; i++) begin
            expect_pairs[i].lo = vals[2*i];
            expect_pairs[i].hi = vals[2*i+1];
        end
    endtask

    task automatic check_reset();
        assert (busy == 1'b0) else mismatch("busy", 32'd0, 32'(busy));
        assert (done == 1'b0) else mismatch("done", 32'd0, 32'(done));
        for (int i = 0; i < N; i++) begin
            assert (sorted[i] == '0)
                else mismatch($sformatf("sorted[%0d]", i), 32'd0, sorted[i]);
        end
    endtask

    task automatic load_one(input sort_pkg::data_t hi, input sort_pkg::data_t lo);
        int slot;
        slot = model_slot;
        load = 1'b1;
        load_pair.hi = hi;
        load_pair.lo = lo;
        @(negedge clk);
        load = 1'b0;
        model[slot] = load_pair;
        model_slot = (model_slot + 1) % N;
        assert (sorted[slot] == model[slot])
            else mismatch($sformatf("sorted[%0d]", slot), model[slot], sorted[slot]);
    endtask

    task automatic load_random(input sort_pkg::data_t mask);
        for (int i = 0; i < N; i++) begin
            rng = xorshift32(rng);
            load_one(rng[31:16] & mask, rng[15:0] & mask);
        end
    endtask

    task automatic check_result();
        for (int i = 0; i < N; i++) begin
            assert (sorted[i] == expect_pairs[i])
                else mismatch($sformatf("sorted[%0d]", i), expect_pairs[i], sorted[i]);
        end
        // the array keeps its result until the next load
        for (int i = 0; i < N; i++) begin
            model[i] = expect_pairs[i];
        end
    endtask

    // start one sort, optionally poking load and start while busy
    task automatic run_sort(input bit inject);
        int cycle;
        bit seen_done;
        start = 1'b1;
        model_slot = 0;
        build_expected();
        cycle = 0;
        seen_done = 1'b0;
        while (!seen_done) begin
            @(negedge clk);
            cycle++;
            start = 1'b0;
            load = 1'b0;
            if (cycle > DONE_TIMEOUT) begin
                stop_run("timeout while waiting for done");
            end
            assert (busy == (cycle <= SORT_CYCLES))
                else mismatch("busy", 32'(cycle <= SORT_CYCLES), 32'(busy));
            assert (done == (cycle == SORT_CYCLES + 1))
                else mismatch("done", 32'(cycle == SORT_CYCLES + 1), 32'(done));
            if (done) begin
                seen_done = 1'b1;
            end else if (inject && cycle <= SORT_CYCLES) begin
                rng = xorshift32(rng);
                load_pair = rng;
                load = rng[0] | (cycle == 3);
                start = rng[1] | (cycle == 2);
            end
        end
        check_result();
        @(negedge clk);
        assert (done == 1'b0) else mismatch("done", 32'd0, 32'(done));
        assert (busy == 1'b0) else mismatch("busy", 32'd0, 32'(busy));
    endtask

    initial begin
        rst = 1'b1;
        load = 1'b0;
        start = 1'b0;
        load_pair = '0;
        rng = SEED;
        model_slot = 0;
        for (int i = 0; i < N; i++) begin
            model[i] = '0;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        check_reset();

        // random data, the masked run forces duplicates
        for (int t = 0; t < 3; t++) begin
            load_random(16'hffff);
            run_sort(1'b0);
        end
        load_random(16'h000f);
        run_sort(1'b0);

        // all equal
        for (int i = 0; i < N; i++) begin
            load_one(16'h5a5a, 16'h5a5a);
        end
        run_sort(1'b0);

        // fully reversed
        for (int i = 0; i < N; i++) begin
            load_one(sort_pkg::data_t'(2 * N - 2 * i - 1), sort_pkg::data_t'(2 * N - 2 * i));
        end
        run_sort(1'b0);

        // extremes mixed
        for (int i = 0; i < N; i++) begin
            load_one((i % 2 == 1) ? 16'h0000 : 16'hffff, (i % 2 == 1) ? 16'hffff : 16'h0000);
        end
        run_sort(1'b0);

        // stray load and start strobes during busy
        load_random(16'hffff);
        run_sort(1'b1);

        // two new pairs merged with the held result
        for (int i = 0; i < 2; i++) begin
            rng = xorshift32(rng);
            load_one(rng[31:16], rng[15:0]);
        end
        run_sort(1'b0);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* dv/tb_clk_gen.sv */
module tb_clk_gen #(
    parameter int PERIOD = 4
) (
    output logic clk
);

    // free running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2);
            clk = ~clk;
        end
    end

endmodule

/* hw/sort4.sv */
module sort4 (
    input  logic            clk,
    input  logic            rst,
    input  logic            sort_en,
    input  sort_pkg::data_t in1,
    input  sort_pkg::data_t in2,
    input  sort_pkg::data_t in3,
    input  sort_pkg::data_t in4,
    output sort_pkg::data_t out_small1,
    output sort_pkg::data_t out_small2,
    output sort_pkg::data_t out_large1,
    output sort_pkg::data_t out_large2,
    output logic            sort_finish
);

    sort_pkg::data_t min_all;
    sort_pkg::data_t mid_lo;
    sort_pkg::data_t mid_hi;
    sort_pkg::data_t max_all;

    // five comparators in three layers
    always_comb begin
        sort_pkg::data_t lo_a;
        sort_pkg::data_t hi_a;
        sort_pkg::data_t lo_b;
        sort_pkg::data_t hi_b;
        sort_pkg::data_t cross_lo;
        sort_pkg::data_t cross_hi;

        // first layer orders each input pair
        lo_a = (in1 < in2) ? in1 : in2;
        hi_a = (in1 < in2) ? in2 : in1;
        lo_b = (in3 < in4) ? in3 : in4;
        hi_b = (in3 < in4) ? in4 : in3;

        // second layer finds the extremes
        min_all  = (lo_a < lo_b) ? lo_a : lo_b;
        cross_lo = (lo_a < lo_b) ? lo_b : lo_a;
        cross_hi = (hi_a < hi_b) ? hi_a : hi_b;
        max_all  = (hi_a < hi_b) ? hi_b : hi_a;

        // last layer settles the middle two
        mid_lo = (cross_lo < cross_hi) ? cross_lo : cross_hi;
        mid_hi = (cross_lo < cross_hi) ? cross_hi : cross_lo;
    end

    always_ff @(posedge clk) begin
        if (sort_en) begin
            out_small1 <= min_all;
            out_small2 <= mid_lo;
            out_large1 <= mid_hi;
            out_large2 <= max_all;
        end
    end

    // results are ready the cycle after sort_en
    always_ff @(posedge clk) begin
        if (rst) begin
            sort_finish <= 1'b0;
        end else begin
            sort_finish <= sort_en;
        end
    end

endmodule

/* hw/sort_array_top.sv */
module sort_array_top #(
    // must be even and at least 2
    parameter int NUM_PE = sort_pkg::NUM_PE_DEFAULT
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            load,
    input  sort_pkg::pair_t load_pair,
    input  logic            start,
    output logic            busy,
    output logic            done,
    output sort_pkg::pair_t sorted [NUM_PE]
);

    localparam int CNT_W = $clog2(NUM_PE);

    sort_pkg::pe_ctrl_t pe_ctrl [NUM_PE];
    logic [NUM_PE-1:0]  pe_write;

    logic [CNT_W-1:0]   slot;
    logic [CNT_W-1:0]   round;
    logic               round_last;
    logic               slot_inc;
    logic               round_clear;
    logic               round_inc;

    // links between neighbours
    sort_pkg::pair_t    to_right [NUM_PE];
    sort_pkg::pair_t    from_left [NUM_PE];
    sort_pkg::pair_t    from_right [NUM_PE];

    sort_ctrl #(
        .NUM_PE (NUM_PE)
    ) u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .load        (load),
        .start       (start),
        .slot        (slot),
        .round_lsb   (round[0]),
        .round_last  (round_last),
        .pe_ctrl     (pe_ctrl),
        .pe_write    (pe_write),
        .slot_inc    (slot_inc),
        .round_clear (round_clear),
        .round_inc   (round_inc),
        .busy        (busy),
        .done        (done)
    );

    // loaded pairs, restarts at slot 0 after each start
    sort_counter #(
        .LIMIT (NUM_PE)
    ) u_slot_cnt (
        .clk   (clk),
        .rst   (rst),
        .clear (round_clear),
        .inc   (slot_inc),
        .count (slot),
        .last  ()
    );

    sort_counter #(
        .LIMIT (NUM_PE)
    ) u_round_cnt (
        .clk   (clk),
        .rst   (rst),
        .clear (round_clear),
        .inc   (round_inc),
        .count (round),
        .last  (round_last)
    );

    for (genvar i = 0; i < NUM_PE; i++) begin : g_pe
        if (i == 0) begin : g_left_end
            assign from_left[i] = '0;
        end else begin : g_left_link
            assign from_left[i] = to_right[i-1];
        end

        if (i == NUM_PE - 1) begin : g_right_end
            assign from_right[i] = '0;
        end else begin : g_right_link
            assign from_right[i] = sorted[i+1];
        end

        sort_pe u_pe (
            .clk        (clk),
            .rst        (rst),
            .write      (pe_write[i]),
            .write_pair (load_pair),
            .ctrl       (pe_ctrl[i]),
            .in_right   (from_right[i]),
            .in_left    (from_left[i]),
            .out_left   (sorted[i]),
            .out_right  (to_right[i])
        );
    end

endmodule

/* hw/sort_counter.sv */
module sort_counter #(
    parameter int LIMIT = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     clear,
    input  logic                     inc,
    output logic [$clog2(LIMIT)-1:0] count,
    output logic                     last
);

    localparam int W = $clog2(LIMIT);
    localparam logic [W-1:0] TOP = W'(LIMIT - 1);

    assign last = (count == TOP);

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (inc) begin
            // wrap after the top value
            if (last) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

/* hw/sort_ctrl.sv */
module sort_ctrl #(
    parameter int NUM_PE = sort_pkg::NUM_PE_DEFAULT
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load,
    input  logic                      start,
    input  logic [$clog2(NUM_PE)-1:0] slot,
    input  logic                      round_lsb,
    input  logic                      round_last,
    output sort_pkg::pe_ctrl_t        pe_ctrl [NUM_PE],
    output logic [NUM_PE-1:0]         pe_write,
    output logic                      slot_inc,
    output logic                      round_clear,
    output logic                      round_inc,
    output logic                      busy,
    output logic                      done
);

    localparam int CNT_W = $clog2(NUM_PE);

    sort_pkg::ctrl_state_t state;
    sort_pkg::ctrl_state_t state_next;

    logic              odd_round;
    logic              write_ok;
    logic [NUM_PE-1:0] left_act;
    logic [NUM_PE-1:0] right_act;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sort_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            sort_pkg::IDLE: begin
                if (start) begin
                    state_next = sort_pkg::RECV;
                end
            end
            sort_pkg::RECV: state_next = sort_pkg::SORT;
            sort_pkg::SORT: state_next = sort_pkg::XFER;
            sort_pkg::XFER: begin
                if (round_last) begin
                    state_next = sort_pkg::DONE;
                end else begin
                    state_next = sort_pkg::RECV;
                end
            end
            sort_pkg::DONE: state_next = sort_pkg::IDLE;
            default: state_next = sort_pkg::IDLE;
        endcase
    end

    assign busy = (state == sort_pkg::RECV) || (state == sort_pkg::SORT) ||
                  (state == sort_pkg::XFER);
    assign done = (state == sort_pkg::DONE);

    // counter strobes
    assign round_clear = (state == sort_pkg::IDLE) && start;
    assign round_inc   = (state == sort_pkg::XFER);
    assign write_ok    = load && !busy;
    assign slot_inc    = write_ok;

    // round 0 is an odd round, so odd elements lead first
    assign odd_round = ~round_lsb;

    always_comb begin
        for (int i = 0; i < NUM_PE; i++) begin
            left_act[i] = ((i % 2 == 1) ? odd_round : ~odd_round) && (i < NUM_PE - 1);
            if (i == 0) begin
                right_act[i] = 1'b0;
            end else begin
                right_act[i] = left_act[i-1];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_PE; i++) begin
            pe_write[i] = write_ok && (slot == CNT_W'(i));
            pe_ctrl[i].receive_right = left_act[i] && (state == sort_pkg::RECV);
            pe_ctrl[i].sort_en       = left_act[i] && (state == sort_pkg::SORT);
            pe_ctrl[i].send_right    = left_act[i] && (state == sort_pkg::XFER);
            pe_ctrl[i].receive_left  = right_act[i] && (state == sort_pkg::XFER);
        end
    end

endmodule

/* hw/sort_pe.sv */
module sort_pe (
    input  logic               clk,
    input  logic               rst,
    input  logic               write,
    input  sort_pkg::pair_t    write_pair,
    input  sort_pkg::pe_ctrl_t ctrl,
    input  sort_pkg::pair_t    in_right,
    input  sort_pkg::pair_t    in_left,
    output sort_pkg::pair_t    out_left,
    output sort_pkg::pair_t    out_right
);

    sort_pkg::pair_t stored;
    sort_pkg::pair_t right_copy;

    sort_pkg::data_t small1;
    sort_pkg::data_t small2;
    sort_pkg::data_t large1;
    sort_pkg::data_t large2;
    logic            sort_finish;

    // own pair, write from the load port wins over everything
    always_ff @(posedge clk) begin
        if (rst) begin
            stored <= '0;
        end else if (write) begin
            stored <= write_pair;
        end else if (ctrl.receive_left) begin
            stored <= in_left;
        end else if (sort_finish) begin
            stored.lo <= small1;
            stored.hi <= small2;
        end
    end

    // neighbour copy only lives for the sort cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            right_copy <= '0;
        end else if (ctrl.receive_right) begin
            right_copy <= in_right;
        end else begin
            right_copy <= '0;
        end
    end

    sort4 u_sort4 (
        .clk         (clk),
        .rst         (rst),
        .sort_en     (ctrl.sort_en),
        .in1         (stored.lo),
        .in2         (stored.hi),
        .in3         (right_copy.lo),
        .in4         (right_copy.hi),
        .out_small1  (small1),
        .out_small2  (small2),
        .out_large1  (large1),
        .out_large2  (large2),
        .sort_finish (sort_finish)
    );

    assign out_left = stored;

    // larges go back to the right neighbour, idle link reads zero
    always_comb begin
        if (ctrl.send_right) begin
            out_right.lo = large1;
            out_right.hi = large2;
        end else begin
            out_right = '0;
        end
    end

endmodule

/* hw/sort_pkg.sv */
package sort_pkg;

    // width of one ranked value
    localparam int DATA_W = 16;

    // element count used when the top level is not overridden
    localparam int NUM_PE_DEFAULT = 4;

    typedef logic [DATA_W-1:0] data_t;

    // lo holds the smaller value once an element has been sorted
    typedef struct packed {
        data_t hi;
        data_t lo;
    } pair_t;

    // per element strobes from the controller
    typedef struct packed {
        logic receive_right;
        logic sort_en;
        logic send_right;
        logic receive_left;
    } pe_ctrl_t;

    typedef enum logic [2:0] {
        IDLE,
        RECV,
        SORT,
        XFER,
        DONE
    } ctrl_state_t;

endpackage

/* run.sh */
#!/bin/sh
# builds the sorting array testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f src.f \
    --top-module sort_array_tb \
    -o sort_array_sim

# a $fatal in the testbench gives a failing exit status here
./obj_dir/sort_array_sim

/* src.f */
hw/sort_pkg.sv
hw/sort4.sv
hw/sort_pe.sv
hw/sort_counter.sv
hw/sort_ctrl.sv
hw/sort_array_top.sv
dv/tb_clk_gen.sv
dv/sort_array_tb.sv
